/* rtl/mpram_pkg.sv */
`default_nettype none

package mpram_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   localparam int DATA_W = 8;          // word width
   localparam int ADDR_W = 5;          // 32 addressable locations

   ////////////////////////////////////////
   // memory request / response
   ////////////////////////////////////////

   typedef enum logic [1:0]
   {
      OP_NONE  = 2'd0,
      OP_READ  = 2'd1,
      OP_WRITE = 2'd2
   } mem_op_e;

   typedef struct packed
   {
      mem_op_e             op;         // valid while not OP_NONE
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
   } mem_req_t;

   typedef struct packed
   {
      logic [DATA_W-1:0]   rdata;      // zero on refused reads
      logic                err;        // address beyond depth
   } mem_rsp_t;

   ////////////////////////////////////////
   // apb port state
   ////////////////////////////////////////

   typedef enum logic [1:0]
   {
      ST_IDLE      = 2'd0,
      ST_ACCESS    = 2'd1,             // first access cycle
      ST_READ_WAIT = 2'd2              // second access cycle, reads only
   } apb_state_e;

endpackage

`default_nettype wire

/* rtl/apb_mem_port.sv */
`default_nettype none

module apb_mem_port
   import mpram_pkg::*;
#(
   parameter int WORDS = 24
)
(
   input  logic              clk,
   input  logic              rst,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [ADDR_W-1:0] paddr,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   output mem_req_t          req,
   input  mem_rsp_t          rsp
);

   apb_state_e        state;
   mem_op_e           op_q;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic              werr;            // refused write, reported with pready
   logic              setup;
   logic              done;
   logic              addr_bad;

   assign setup    = psel && !penable;
   assign done     = psel && penable && pready;
   assign addr_bad = int'(paddr) >= WORDS;

   ////////////////////////////////////////
   // transfer FSM
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state  <= ST_IDLE;
         op_q   <= OP_NONE;
         pready <= 1'b0;
         werr   <= 1'b0;
      end
      else
      begin
         op_q <= OP_NONE;              // request lasts one cycle
         case (state)
            ST_IDLE:
            begin
               if (setup)
               begin
                  state  <= ST_ACCESS;
                  pready <= pwrite;    // writes have no wait state
                  werr   <= pwrite && addr_bad;
                  if (!pwrite)
                     op_q <= OP_READ;  // range checked by the array
                  else if (!addr_bad)
                     op_q <= OP_WRITE;
               end
            end

            ST_ACCESS:
            begin
               if (done)
               begin
                  state  <= ST_IDLE;
                  pready <= 1'b0;
                  werr   <= 1'b0;
               end
               else if (!psel)         // master dropped the transfer
               begin
                  state  <= ST_IDLE;
                  pready <= 1'b0;
                  werr   <= 1'b0;
               end
               else if (!pwrite)
               begin
                  state  <= ST_READ_WAIT;
                  pready <= 1'b1;      // rsp arrives at this edge
               end
            end

            ST_READ_WAIT:
            begin
               if (done || !psel)
               begin
                  state  <= ST_IDLE;
                  pready <= 1'b0;
               end
            end

            default:
            begin
               state  <= ST_IDLE;
               pready <= 1'b0;
               werr   <= 1'b0;
            end
         endcase
      end
   end

   // payload follows the setup phase
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && setup)
      begin
         addr_q  <= paddr;
         wdata_q <= pwdata;
      end
   end

   assign req = '{op: op_q, addr: addr_q, wdata: wdata_q};

   assign prdata  = (state == ST_READ_WAIT) ? rsp.rdata : '0;
   assign pslverr = (state == ST_READ_WAIT) ? rsp.err : werr;

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   a_req_single: assert property (@(posedge clk) disable iff (rst)
      req.op != OP_NONE |=> req.op == OP_NONE)
      else $error("request held longer than one cycle");

   a_ready_in_access: assert property (@(posedge clk) disable iff (rst)
      pready |-> psel && penable)
      else $error("pready outside an access phase");

   // master must hold the address until completion
   a_addr_stable: assert property (@(posedge clk) disable iff (rst)
      psel && !done |=> $stable(paddr))
      else $error("paddr changed during a transfer");

endmodule

`default_nettype wire

/* rtl/mpram_2r2w.sv */
`default_nettype none

module mpram_2r2w
   import mpram_pkg::*;
#(
   parameter int WORDS = 24
)
(
   input  logic     clk,
   input  logic     rst,
   input  mem_req_t req0,
   input  mem_req_t req1,
   output mem_rsp_t rsp0,
   output mem_rsp_t rsp1
);

   logic [DATA_W-1:0] mem [WORDS];
   logic              we0;
   logic              we1;

   function automatic logic in_range(input logic [ADDR_W-1:0] addr);
      return int'(addr) < WORDS;
   endfunction

   // one read port, old contents on a same-cycle write
   function automatic mem_rsp_t read_word(input mem_req_t r);
      mem_rsp_t res;
      res = '0;
      if (r.op == OP_READ)
      begin
         if (in_range(r.addr))
            res.rdata = mem[r.addr];
         else
            res.err = 1'b1;         // refused, rdata stays 0
      end
      return res;
   endfunction

   assign we0 = (req0.op == OP_WRITE) && in_range(req0.addr);
   assign we1 = (req1.op == OP_WRITE) && in_range(req1.addr);

   ////////////////////////////////////////
   // storage
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < WORDS; i++)
            mem[i] <= '0;
      end
      else
      begin
         if (we0)
            mem[req0.addr] <= req0.wdata;
         if (we1)
            mem[req1.addr] <= req1.wdata;  // port 1 wins a collision
      end
   end

   ////////////////////////////////////////
   // read responses, one cycle after req
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rsp0 <= '0;
         rsp1 <= '0;
      end
      else
      begin
         rsp0 <= read_word(req0);
         rsp1 <= read_word(req1);
      end
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   // the ports refuse bad writes before they reach the array
   a_wr_range0: assert property (@(posedge clk) disable iff (rst)
      req0.op == OP_WRITE |-> int'(req0.addr) < WORDS)
      else $error("port 0 write beyond depth reached the array");

   a_wr_range1: assert property (@(posedge clk) disable iff (rst)
      req1.op == OP_WRITE |-> int'(req1.addr) < WORDS)
      else $error("port 1 write beyond depth reached the array");

endmodule

`default_nettype wire

/* rtl/mpram_subsys.sv */
`default_nettype none

module mpram_subsys
   import mpram_pkg::*;
#(
   parameter int WORDS = 24
)
(
   input  logic              clk,
   input  logic              rst,

   // port 0
   input  logic              psel0,
   input  logic              penable0,
   input  logic              pwrite0,
   input  logic [ADDR_W-1:0] paddr0,
   input  logic [DATA_W-1:0] pwdata0,
   output logic [DATA_W-1:0] prdata0,
   output logic              pready0,
   output logic              pslverr0,

   // port 1
   input  logic              psel1,
   input  logic              penable1,
   input  logic              pwrite1,
   input  logic [ADDR_W-1:0] paddr1,
   input  logic [DATA_W-1:0] pwdata1,
   output logic [DATA_W-1:0] prdata1,
   output logic              pready1,
   output logic              pslverr1
);

   mem_req_t req0;
   mem_req_t req1;
   mem_rsp_t rsp0;
   mem_rsp_t rsp1;

   ////////////////////////////////////////
   // apb ports
   ////////////////////////////////////////

   apb_mem_port #(.WORDS(WORDS)) u_port0
   (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel0),
      .penable (penable0),
      .pwrite  (pwrite0),
      .paddr   (paddr0),
      .pwdata  (pwdata0),
      .prdata  (prdata0),
      .pready  (pready0),
      .pslverr (pslverr0),
      .req     (req0),
      .rsp     (rsp0)
   );

   apb_mem_port #(.WORDS(WORDS)) u_port1
   (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel1),
      .penable (penable1),
      .pwrite  (pwrite1),
      .paddr   (paddr1),
      .pwdata  (pwdata1),
      .prdata  (prdata1),
      .pready  (pready1),
      .pslverr (pslverr1),
      .req     (req1),
      .rsp     (rsp1)
   );

   ////////////////////////////////////////
   // shared array
   ////////////////////////////////////////

   mpram_2r2w #(.WORDS(WORDS)) u_ram
   (
      .clk  (clk),
      .rst  (rst),
      .req0 (req0),
      .req1 (req1),              // priority side on collisions
      .rsp0 (rsp0),
      .rsp1 (rsp1)
   );

endmodule

`default_nettype wire

/* test/tb_apb_tasks.svh */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

////////////////////////////////////////
// random numbers
////////////////////////////////////////

function automatic logic [31:0] xorshift(input logic [31:0] x);
   logic [31:0] y;
   y = x;
   y = y ^ (y << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

////////////////////////////////////////
// reporting
////////////////////////////////////////

function automatic void report_mismatch(input string name, input logic [31:0] expected,
                                        input logic [31:0] got);
   $display("MISMATCH t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, got);
   err_count++;
endfunction

task automatic start_test(input string name);
   test_name = name;
   test_errs = err_count;
endtask

task automatic end_test();
   int errs;
   errs = err_count - test_errs;
   n_tests++;
   if (errs != 0)
      n_failed++;
   $display("[%0t] test %0d %s: %s (%0d errors)", $time, n_tests, test_name,
            (errs == 0) ? "ok" : "FAILED", errs);
endtask

////////////////////////////////////////
// apb master
////////////////////////////////////////

// pready is looked at on the falling edge, away from the DUT's updates
task automatic wait_ready(input int port, input string kind, input logic [ADDR_W-1:0] addr);
   int n;
   n = 0;
   while (!pready[port] && n < READY_LIMIT)
   begin
      @(negedge clk);
      n++;
   end
   if (!pready[port])
   begin
      $display("port %0d %s at 0x%0h got no pready within %0d cycles", port, kind, addr, n);
      err_count++;
   end
endtask

task automatic apb_write(input int port, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data);
   @(negedge clk);
   psel[port]    = 1'b1;          // setup phase
   penable[port] = 1'b0;
   pwrite[port]  = 1'b1;
   paddr[port]   = addr;
   pwdata[port]  = data;
   @(negedge clk);
   penable[port] = 1'b1;
   wait_ready(port, "write", addr);
   @(negedge clk);
   psel[port]    = 1'b0;
   penable[port] = 1'b0;
   n_xfer++;
endtask

task automatic apb_read(input int port, input logic [ADDR_W-1:0] addr);
   @(negedge clk);
   psel[port]    = 1'b1;
   penable[port] = 1'b0;
   pwrite[port]  = 1'b0;
   paddr[port]   = addr;
   @(negedge clk);
   penable[port] = 1'b1;
   wait_ready(port, "read", addr);
   @(negedge clk);
   psel[port]    = 1'b0;
   penable[port] = 1'b0;
   n_xfer++;
endtask

`endif

/* test/tb_mpram_subsys.sv */
`default_nettype none

module tb_mpram_subsys
   import mpram_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int WORDS       = 24;
   localparam int CLK_PERIOD  = 20;
   localparam int RESET_CYC   = 5;
   localparam int N_RAND      = 12;
   localparam int N_COLL      = 4;
   localparam int READY_LIMIT = 8;
   localparam int N_BAD       = (1 << ADDR_W) - WORDS;     // out-of-range addresses
   localparam int N_XFERS     = 2 * WORDS + 8 * N_RAND + 6 * N_COLL + 4 * N_BAD;

   logic              clk;
   logic              rst;
   logic              psel    [2];
   logic              penable [2];
   logic              pwrite  [2];
   logic [ADDR_W-1:0] paddr   [2];
   logic [DATA_W-1:0] pwdata  [2];
   logic [DATA_W-1:0] prdata  [2];
   logic              pready  [2];
   logic              pslverr [2];

   logic [DATA_W-1:0] ref_mem [WORDS];
   logic [31:0]       rng;
   int                err_count;
   int                test_errs;
   int                n_tests;
   int                n_failed;
   int                n_xfer;
   string             test_name;

   `include "tb_apb_tasks.svh"

   initial
      clk = 1'b0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   mpram_subsys #(.WORDS(WORDS)) u_mpram_subsys
   (
      .clk      (clk),
      .rst      (rst),
      .psel0    (psel[0]),
      .penable0 (penable[0]),
      .pwrite0  (pwrite[0]),
      .paddr0   (paddr[0]),
      .pwdata0  (pwdata[0]),
      .prdata0  (prdata[0]),
      .pready0  (pready[0]),
      .pslverr0 (pslverr[0]),
      .psel1    (psel[1]),
      .penable1 (penable[1]),
      .pwrite1  (pwrite[1]),
      .paddr1   (paddr[1]),
      .pwdata1  (pwdata[1]),
      .prdata1  (prdata[1]),
      .pready1  (pready[1]),
      .pslverr1 (pslverr[1])
   );

   ////////////////////////////////////////
   // reference array
   ////////////////////////////////////////

   always @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < WORDS; i++)
            ref_mem[i] <= '0;
      end
      else
      begin
         for (int p = 0; p < 2; p++)   // port 1 last, so it wins
            if (psel[p] && penable[p] && pwrite[p] && int'(paddr[p]) < WORDS)
               ref_mem[paddr[p]] <= pwdata[p];
      end
   end

   ////////////////////////////////////////
   // per-port checks
   ////////////////////////////////////////

   for (genvar p = 0; p < 2; p++)
   begin : g_chk
      int                acc;          // access cycles so far
      logic [DATA_W-1:0] exp_rd;
      logic              xfer_done;

      assign xfer_done = psel[p] && penable[p] && pready[p];

      // array is sampled in the first access cycle, before that edge's writes
      always @(posedge clk)
      begin
         if (rst)
         begin
            acc    <= 0;
            exp_rd <= '0;
         end
         else
         begin
            acc <= (psel[p] && penable[p]) ? acc + 1 : 0;
            if (psel[p] && penable[p] && !pwrite[p] && acc == 0)
               exp_rd <= (int'(paddr[p]) < WORDS) ? ref_mem[paddr[p]] : '0;
         end
      end

      a_wr_ready: assert property (@(posedge clk) disable iff (rst)
         psel[p] && penable[p] && pwrite[p] |-> pready[p])
         else report_mismatch($sformatf("pready%0d", p), 1, $sampled(pready[p]));

      // one wait state on reads
      a_rd_ready: assert property (@(posedge clk) disable iff (rst)
         psel[p] && penable[p] && !pwrite[p] |-> pready[p] == (acc == 1))
         else report_mismatch($sformatf("pready%0d", p), $sampled(acc == 1),
                              $sampled(pready[p]));

      a_rd_data: assert property (@(posedge clk) disable iff (rst)
         xfer_done && !pwrite[p] |-> prdata[p] == exp_rd)
         else report_mismatch($sformatf("prdata%0d", p), $sampled(exp_rd),
                              $sampled(prdata[p]));

      a_err: assert property (@(posedge clk) disable iff (rst)
         xfer_done |-> pslverr[p] == (int'(paddr[p]) >= WORDS))
         else report_mismatch($sformatf("pslverr%0d", p),
                              int'($sampled(paddr[p])) >= WORDS, $sampled(pslverr[p]));

      a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
         !psel[p] |-> !pready[p] && !pslverr[p])
         else report_mismatch($sformatf("{pready%0d,pslverr%0d}", p, p), 0,
                              $sampled({pready[p], pslverr[p]}));
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial
   begin
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      rst = 1'b1;
      for (int p = 0; p < 2; p++)
      begin
         psel[p]    = 1'b0;
         penable[p] = 1'b0;
         pwrite[p]  = 1'b0;
         paddr[p]   = '0;
         pwdata[p]  = '0;
      end
      rng       = 32'hd4f7f713;
      err_count = 0;
      test_errs = 0;
      n_tests   = 0;
      n_failed  = 0;
      n_xfer    = 0;
      repeat (RESET_CYC) @(negedge clk);
      rst = 1'b0;

      start_test("reset_contents");
      for (int a = 0; a < WORDS; a++)
         apb_read(a % 2, ADDR_W'(a));
      end_test();

      start_test("write_read");
      for (int p = 0; p < 2; p++)
         for (int i = 0; i < N_RAND; i++)
         begin
            rng  = xorshift(rng);
            addr = ADDR_W'(rng % WORDS);
            data = rng[31:24];
            apb_write(p, addr, data);
            apb_read(p, addr);
         end
      end_test();

      start_test("cross_port");
      for (int i = 0; i < N_RAND; i++)
      begin
         rng  = xorshift(rng);
         addr = ADDR_W'(rng % WORDS);
         apb_write(0, addr, rng[31:24]);
         apb_read(1, addr);
         addr = ADDR_W'(rng[23:16] % WORDS);
         apb_write(1, addr, rng[15:8]);
         apb_read(0, addr);
      end
      end_test();

      start_test("collision");
      for (int i = 0; i < N_COLL; i++)
      begin
         rng  = xorshift(rng);
         addr = ADDR_W'(rng % WORDS);
         data = rng[31:24];
         fork
            apb_write(0, addr, data);
            apb_write(1, addr, ~data);
         join
         apb_read(0, addr);
         rng = xorshift(rng);
         fork
            apb_write(0, addr, rng[7:0]);
            apb_read(1, addr);     // old value expected
         join
         apb_read(1, addr);
      end
      end_test();

      start_test("out_of_range");
      for (int a = WORDS; a < (1 << ADDR_W); a++)
      begin
         rng = xorshift(rng);
         fork
            apb_write(0, ADDR_W'(a), rng[7:0]);
            apb_write(1, ADDR_W'(a), rng[15:8]);
         join
         fork
            apb_read(0, ADDR_W'(a));
            apb_read(1, ADDR_W'(a));
         join
      end
      for (int a = 0; a < WORDS; a++)
         apb_read(a % 2, ADDR_W'(a));
      end_test();

      $display("%0d tests, %0d failed, %0d errors, %0d transfers",
               n_tests, n_failed, err_count, n_xfer);
      if (err_count == 0 && n_failed == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // at most 4 cycles per transfer
   initial
   begin
      #((N_XFERS * 4 + RESET_CYC + 50) * CLK_PERIOD);
      $display("watchdog expired at %0t before the tests finished", $time);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+test
rtl/mpram_pkg.sv
rtl/apb_mem_port.sv
rtl/mpram_2r2w.sv
rtl/mpram_subsys.sv
test/tb_mpram_subsys.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_mpram_subsys
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
